// File: cart.f
+incdir+tb
common/cart_pkg.sv
mapper/map_config.sv
mapper/bank_regs.sv
mapper/addr_translate.sv
source/covox.sv
source/cart_top.sv
tb/tb_cart.sv

// File: common/cart_pkg.sv
////////////////////////////////////////////////////////////
// shared widths, mapping enums and bus/config structs
////////////////////////////////////////////////////////////
`default_nettype none

package cart_pkg;

	typedef logic [15:0] addr_t;
	typedef logic [7:0]  byte_t;

	// 8-bit bank above a 14-bit offset
	typedef logic [21:0] rom_addr_t;

	// 3-bit ram bank above a 14-bit offset
	typedef logic [16:0] ram_addr_t;

	// 8K regions, indexed by address[15:13]
	localparam int region_count = 8;

	// what answers inside one region
	typedef enum logic [1:0] {
		hw_open   = 2'd0,
		hw_rom    = 2'd1,
		hw_ram    = 2'd2,
		hw_banked = 2'd3
	} hw_kind_e;

	typedef enum logic [1:0] {
		bank_supergame  = 2'd0,
		bank_activision = 2'd1,
		bank_none       = 2'd2,
		bank_absolute   = 2'd3
	} bank_type_e;

	// one cpu bus cycle with rw high for read
	typedef struct packed {
		addr_t address;
		byte_t data;
		logic  rw;
		logic  cart_cs;
	} cpu_bus_t;

	// cart type bits taken from the header word
	typedef struct packed {
		logic supergame;
		logic sg_ram_4k;
		logic rom_9bank;
		logic bank6_4k;
		logic sg_banked_ram;
		logic mirror_ram;
		logic activision;
		logic absolute;
		// 8K ram at $6000 with its ram bank in the bank write
		logic sg_ram_alt;
	} cart_flags_t;

	// registered memory map, one entry per region
	typedef struct packed {
		hw_kind_e [region_count-1:0] hw_map;
		byte_t    [region_count-1:0] bank_map;
		bank_type_e                  bank_type;
		byte_t                       bank_mask;
		ram_addr_t                   ram_mask;
		addr_t                       rom_offset;
	} map_cfg_t;

	typedef struct packed {
		byte_t      bank_reg;
		logic [2:0] ram_bank;
	} bank_state_t;

endpackage

`default_nettype wire

// File: mapper/addr_translate.sv
////////////////////////////////////////////////////////////
// region decode, rom and cart ram addressing, read mux
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module addr_translate (
	input  cart_pkg::cpu_bus_t  bus,
	input  cart_pkg::map_cfg_t  cfg,
	input  cart_pkg::byte_t     rom_data,
	input  cart_pkg::byte_t     ram_data,
	input  cart_pkg::byte_t     open_bus,
	output cart_pkg::rom_addr_t rom_address,
	output cart_pkg::ram_addr_t cartram_addr,
	output logic                cartram_wr,
	output logic                cartram_rd,
	output cart_pkg::byte_t     cartram_wrdata,
	output cart_pkg::byte_t     dout,
	output logic                cart_read
);
	import cart_pkg::*;

	logic [2:0] region;
	hw_kind_e   kind;
	byte_t      region_bank;
	addr_t      flat_addr;
	logic       ram_sel;

	assign region      = bus.address[15:13];
	assign kind        = cfg.hw_map[region];
	assign region_bank = cfg.bank_map[region];

	// linear rom sits at the top of the 64K space
	assign flat_addr = bus.address - cfg.rom_offset;

	always_comb begin
		rom_address = '0;
		ram_sel     = 1'b0;
		if (bus.cart_cs) begin
			case (kind)
				hw_rom: rom_address = {6'd0, flat_addr};
				hw_banked: begin
					case (cfg.bank_type)
						bank_supergame,
						bank_absolute:   rom_address = {region_bank, bus.address[13:0]};
						// activision banks are 8K wide
						bank_activision: rom_address = {1'b0, region_bank, bus.address[12:0]};
						default:         rom_address = {6'd0, flat_addr};
					endcase
				end
				hw_ram: ram_sel = 1'b1;
				default: begin
				end
			endcase
		end
	end

	// ram regions hold ram_bank in the low bits of their bank_map
	assign cartram_addr   = {region_bank[2:0], bus.address[13:0]} & cfg.ram_mask;
	assign cartram_wr     = ram_sel && !bus.rw;
	assign cartram_rd     = ram_sel && bus.rw;
	assign cartram_wrdata = bus.data;

	always_comb begin
		case (kind)
			hw_rom,
			hw_banked: dout = rom_data;
			hw_ram:    dout = ram_data;
			default:   dout = open_bus;
		endcase
	end

	// cart ram reads are served by the ram, not the rom port
	assign cart_read = bus.rw && bus.cart_cs && !ram_sel;

	// only the $4000-$7fff regions may map to cart ram
	always_comb begin
		a_ram_window: assert final (!ram_sel || bus.address[15:14] == 2'b01)
			else $error("cart ram selected outside $4000-$7fff");
	end

endmodule

`default_nettype wire

// File: mapper/bank_regs.sv
////////////////////////////////////////////////////////////
// bank and ram bank registers on the cpu write side
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module bank_regs (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  pclk0,
	input  cart_pkg::cpu_bus_t    bus,
	input  cart_pkg::map_cfg_t    cfg,
	input  cart_pkg::cart_flags_t flags,
	output cart_pkg::bank_state_t bank
);
	import cart_pkg::*;

	logic bus_write;

	assign bus_write = pclk0 && bus.cart_cs && !bus.rw;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bank.bank_reg <= 8'd0;
			bank.ram_bank <= 3'd0;
		end else if (bus_write) begin
			case (cfg.bank_type)
				// supergame latch lives at $8000-$bfff
				bank_supergame: begin
					if (bus.address[15:14] == 2'b10) begin
						if (flags.sg_ram_alt) begin
							bank.ram_bank <= bus.data[7:5];
							bank.bank_reg <= {3'd0, bus.data[4:0]};
						end else begin
							bank.bank_reg <= bus.data;
						end
					end
				end
				// activision takes the bank from the address
				bank_activision: begin
					if (bus.address[15:4] == 12'hff8)
						bank.bank_reg <= {5'd0, bus.address[2:0]};
				end
				bank_absolute: begin
					if (bus.address[15])
						bank.bank_reg <= {6'd0, bus.data[1:0]};
				end
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: mapper/map_config.sv
////////////////////////////////////////////////////////////
// per-region hardware and bank map loaded on pclk1
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module map_config (
	input  logic                  clk_sys,
	input  logic                  pclk1,
	input  cart_pkg::cart_flags_t flags,
	input  logic [31:0]           cart_size,
	input  cart_pkg::bank_state_t bank,
	output cart_pkg::map_cfg_t    cfg
);
	import cart_pkg::*;

	map_cfg_t next_cfg;
	byte_t    size_mask;
	byte_t    top_bank;
	byte_t    low_bank;
	byte_t    sg_bank;
	logic     is_supergame;
	logic     any_banked;

	// mask from the highest set size bit of 32K and up
	always_comb begin
		size_mask = 8'h00;
		for (int i = 15; i <= 22; i++) begin
			if (cart_size[i])
				size_mask = byte_t'((9'd1 << (i - 14)) - 9'd1);
		end
	end

	// 9-bank carts shift the switched window up by one
	assign top_bank     = size_mask + byte_t'(flags.rom_9bank);
	assign low_bank     = flags.rom_9bank ? 8'h00 : (size_mask & 8'hfe);
	assign sg_bank      = (bank.bank_reg & size_mask) + byte_t'(flags.rom_9bank);
	assign is_supergame = flags.supergame || (cart_size >= 32'h10000);

	always_comb begin
		next_cfg           = '0;
		next_cfg.bank_mask = 8'hff;
		next_cfg.ram_mask  = '1;
		next_cfg.bank_type = bank_none;

		if (flags.activision) begin
			for (int r = 2; r < region_count; r++)
				next_cfg.hw_map[r] = hw_banked;
			next_cfg.bank_map[2] = 8'd13;
			next_cfg.bank_map[3] = 8'd12;
			next_cfg.bank_map[4] = 8'd15;
			next_cfg.bank_map[5] = {4'd0, bank.bank_reg[2:0], 1'b0};
			next_cfg.bank_map[6] = {4'd0, bank.bank_reg[2:0], 1'b1};
			next_cfg.bank_map[7] = 8'd14;
			next_cfg.bank_type   = bank_activision;
		end else if (flags.absolute) begin
			for (int r = 2; r < region_count; r++)
				next_cfg.hw_map[r] = hw_banked;
			next_cfg.bank_map[2] = {7'd0, bank.bank_reg[1]};
			next_cfg.bank_map[3] = {7'd0, bank.bank_reg[1]};
			next_cfg.bank_map[4] = 8'd2;
			next_cfg.bank_map[5] = 8'd2;
			next_cfg.bank_map[6] = 8'd3;
			next_cfg.bank_map[7] = 8'd3;
			next_cfg.bank_type   = bank_absolute;
		end else if (is_supergame) begin
			for (int r = 2; r < region_count; r++)
				next_cfg.hw_map[r] = hw_banked;
			next_cfg.bank_map[2] = low_bank;
			next_cfg.bank_map[3] = low_bank;
			next_cfg.bank_map[4] = sg_bank;
			next_cfg.bank_map[5] = sg_bank;
			next_cfg.bank_map[6] = top_bank;
			next_cfg.bank_map[7] = top_bank;
			next_cfg.bank_mask   = size_mask;
			next_cfg.bank_type   = bank_supergame;
		end else begin
			// flat 8K to 48K rom ends at $ffff
			for (int r = 2; r < region_count; r++) begin
				if ((cart_size <= 32'h2000 && r >= 7) ||
					(cart_size > 32'h2000 && cart_size <= 32'h4000 && r >= 6) ||
					(cart_size > 32'h4000 && cart_size <= 32'h8000 && r >= 4) ||
					(cart_size > 32'h8000 && cart_size <= 32'hc000))
					next_cfg.hw_map[r] = hw_rom;
			end
			next_cfg.rom_offset = addr_t'(32'h10000 - cart_size);
		end

		// $4000 options; ram regions carry ram_bank in their bank_map
		if (flags.sg_ram_4k || flags.sg_banked_ram || flags.sg_ram_alt ||
			flags.mirror_ram) begin
			for (int r = 2; r < 4; r++) begin
				next_cfg.hw_map[r]   = hw_ram;
				next_cfg.bank_map[r] = {5'd0, bank.ram_bank};
			end
			if (flags.mirror_ram &&
				!(flags.sg_ram_4k || flags.sg_banked_ram || flags.sg_ram_alt)) begin
				next_cfg.ram_mask[8]     = 1'b0;
				next_cfg.ram_mask[13:12] = 2'b00;
			end
		end else if (flags.bank6_4k) begin
			next_cfg.hw_map[2]   = hw_banked;
			next_cfg.hw_map[3]   = hw_banked;
			next_cfg.bank_map[2] = 8'd6;
			next_cfg.bank_map[3] = 8'd6;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (pclk1)
			cfg <= next_cfg;
	end

	always_comb begin
		any_banked = 1'b0;
		for (int r = 0; r < region_count; r++) begin
			if (cfg.hw_map[r] == hw_banked)
				any_banked = 1'b1;
		end
	end

	// a flat 9-bank flag alone must not turn on banking
	a_flat_9bank: assert property (@(posedge clk_sys)
		pclk1 && flags.rom_9bank && !is_supergame && !flags.activision
			&& !flags.absolute && !flags.bank6_4k
		|=> !any_banked);

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build the cart mapper testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_cart \
	-f cart.f \
	-o tb_cart

./obj_dir/tb_cart

// File: source/cart_top.sv
////////////////////////////////////////////////////////////
// cart mapper top with map config, bank regs, decode and covox
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module cart_top (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  cart_pkg::cpu_bus_t    bus,
	input  logic                  pclk0,
	input  logic                  pclk1,
	input  cart_pkg::cart_flags_t flags,
	input  logic [31:0]           cart_size,
	input  cart_pkg::byte_t       rom_data,
	input  cart_pkg::byte_t       ram_data,
	input  cart_pkg::byte_t       open_bus,
	output cart_pkg::byte_t       dout,
	output logic                  cart_read,
	output cart_pkg::rom_addr_t   rom_address,
	output cart_pkg::ram_addr_t   cartram_addr,
	output logic                  cartram_wr,
	output logic                  cartram_rd,
	output cart_pkg::byte_t       cartram_wrdata,
	output logic [15:0]           covox_l,
	output logic [15:0]           covox_r
);
	import cart_pkg::*;

	map_cfg_t    cfg;
	bank_state_t bank;

	map_config u_map_config (
		.clk_sys   (clk_sys),
		.pclk1     (pclk1),
		.flags     (flags),
		.cart_size (cart_size),
		.bank      (bank),
		.cfg       (cfg)
	);

	bank_regs u_bank_regs (
		.clk_sys (clk_sys),
		.reset   (reset),
		.pclk0   (pclk0),
		.bus     (bus),
		.cfg     (cfg),
		.flags   (flags),
		.bank    (bank)
	);

	addr_translate u_addr_translate (
		.bus            (bus),
		.cfg            (cfg),
		.rom_data       (rom_data),
		.ram_data       (ram_data),
		.open_bus       (open_bus),
		.rom_address    (rom_address),
		.cartram_addr   (cartram_addr),
		.cartram_wr     (cartram_wr),
		.cartram_rd     (cartram_rd),
		.cartram_wrdata (cartram_wrdata),
		.dout           (dout),
		.cart_read      (cart_read)
	);

	covox u_covox (
		.clk_sys (clk_sys),
		.reset   (reset),
		.pclk0   (pclk0),
		.bus     (bus),
		.covox_l (covox_l),
		.covox_r (covox_r)
	);

endmodule

`default_nettype wire

// File: source/covox.sv
////////////////////////////////////////////////////////////
// covox dac registers at $430-$433
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module covox (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               pclk0,
	input  cart_pkg::cpu_bus_t bus,
	output logic [15:0]        covox_l,
	output logic [15:0]        covox_r
);
	import cart_pkg::*;

	byte_t covox_reg [4];
	logic  reg_write;

	assign reg_write = pclk0 && bus.cart_cs && !bus.rw && (bus.address[15:2] == 14'h010c);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			for (int i = 0; i < 4; i++)
				covox_reg[i] <= 8'd0;
		end else if (reg_write) begin
			covox_reg[bus.address[1:0]] <= bus.data;
		end
	end

	// 9-bit sums scaled up so the channels are not too quiet
	assign covox_r = {{1'b0, covox_reg[0]} + {1'b0, covox_reg[2]}, 7'd0};
	assign covox_l = {{1'b0, covox_reg[1]} + {1'b0, covox_reg[3]}, 7'd0};

endmodule

`default_nettype wire

// File: tb/cart_tests.svh
////////////////////////////////////////////////////////////
// bus drive tasks and one directed test per behavior
////////////////////////////////////////////////////////////
`ifndef cart_tests_svh
`define cart_tests_svh

task automatic idle_bus();
	bus.address = 16'h0000;
	bus.data    = 8'h00;
	bus.rw      = 1'b1;
	bus.cart_cs = 1'b0;
endtask

// new cart type latched by one pclk1 strobe
task automatic load_cart(input cart_flags_t cart_flags, input logic [31:0] size);
	@(posedge clk_sys);
	#drive_skew;
	flags     = cart_flags;
	cart_size = size;
	pclk1     = 1'b1;
	idle_bus();
	@(posedge clk_sys);
	#drive_skew;
	pclk1 = 1'b0;
endtask

task automatic apply_reset();
	@(posedge clk_sys);
	#drive_skew;
	reset = 1'b1;
	repeat (2) @(posedge clk_sys);
	#drive_skew;
	reset = 1'b0;
endtask

// cpu write on pclk0, then pclk1 so the map follows the bank
task automatic bus_write(input addr_t address, input byte_t data);
	@(posedge clk_sys);
	#drive_skew;
	bus.address = address;
	bus.data    = data;
	bus.rw      = 1'b0;
	bus.cart_cs = 1'b1;
	pclk0       = 1'b1;
	@(posedge clk_sys);
	#drive_skew;
	pclk0 = 1'b0;
	pclk1 = 1'b1;
	idle_bus();
	@(posedge clk_sys);
	#drive_skew;
	pclk1 = 1'b0;
endtask

// one strobe-free bus cycle that returns mid-cycle for sampling
task automatic present_bus(input addr_t address, input byte_t data, input logic rw);
	@(posedge clk_sys);
	#drive_skew;
	bus.address = address;
	bus.data    = data;
	bus.rw      = rw;
	bus.cart_cs = 1'b1;
	// fresh memory bytes each cycle so the read mux is visible
	rom_data = byte_t'(next_random());
	ram_data = byte_t'(next_random());
	open_bus = byte_t'(next_random());
	@(negedge clk_sys);
endtask

task automatic unbanked_16k_reads();
	logic [31:0] offset;
	load_cart('0, 32'h4000);
	for (int i = 0; i < 8; i++) begin
		offset = next_random() & 32'h3fff;
		present_bus(16'hc000 | addr_t'(offset), 8'h00, 1'b1);
		check_value("rom_address", offset, 32'(rom_address));
		check_value("dout", 32'(rom_data), 32'(dout));
		check_value("cart_read", 32'd1, 32'(cart_read));
	end
	// nothing answers at $8000 on a 16K cart
	present_bus(16'h8000, 8'h00, 1'b1);
	check_value("dout", 32'(open_bus), 32'(dout));
endtask

task automatic supergame_128k_banking();
	cart_flags_t cart_flags;
	logic [31:0] offset;
	byte_t       bank;
	cart_flags           = '0;
	cart_flags.supergame = 1'b1;
	load_cart(cart_flags, 32'h20000);
	for (int i = 0; i < 6; i++) begin
		offset = next_random() & 32'h3fff;
		present_bus(16'hc000 | addr_t'(offset), 8'h00, 1'b1);
		check_value("rom_address", (32'd7 << 14) | offset, 32'(rom_address));
		present_bus(16'h4000 | addr_t'(offset), 8'h00, 1'b1);
		check_value("rom_address", (32'd6 << 14) | offset, 32'(rom_address));
	end
	for (int i = 0; i < 6; i++) begin
		bank = byte_t'(next_random());
		bus_write(16'h8000, bank);
		offset = next_random() & 32'h3fff;
		present_bus(16'h8000 | addr_t'(offset), 8'h00, 1'b1);
		check_value("rom_address", ((32'(bank) & 32'd7) << 14) | offset, 32'(rom_address));
	end
endtask

task automatic activision_banking();
	cart_flags_t cart_flags;
	logic [31:0] offset;
	cart_flags            = '0;
	cart_flags.activision = 1'b1;
	load_cart(cart_flags, 32'h20000);
	// bank 5 selects the 8K pair 10 and 11
	bus_write(16'hff85, 8'h00);
	for (int i = 0; i < 4; i++) begin
		offset = next_random() & 32'h1fff;
		present_bus(16'ha000 | addr_t'(offset), 8'h00, 1'b1);
		check_value("rom_address", (32'd10 << 13) | offset, 32'(rom_address));
		present_bus(16'hc000 | addr_t'(offset), 8'h00, 1'b1);
		check_value("rom_address", (32'd11 << 13) | offset, 32'(rom_address));
		present_bus(16'he000 | addr_t'(offset), 8'h00, 1'b1);
		check_value("rom_address", (32'd14 << 13) | offset, 32'(rom_address));
	end
endtask

task automatic absolute_banking();
	cart_flags_t cart_flags;
	logic [31:0] offset;
	cart_flags          = '0;
	cart_flags.absolute = 1'b1;
	load_cart(cart_flags, 32'h10000);
	bus_write(16'h8000, 8'h02);
	for (int i = 0; i < 4; i++) begin
		offset = next_random() & 32'h3fff;
		present_bus(16'h4000 | addr_t'(offset), 8'h00, 1'b1);
		check_value("rom_address", (32'd1 << 14) | offset, 32'(rom_address));
		present_bus(16'h8000 | addr_t'(offset), 8'h00, 1'b1);
		check_value("rom_address", (32'd2 << 14) | offset, 32'(rom_address));
		present_bus(16'hc000 | addr_t'(offset), 8'h00, 1'b1);
		check_value("rom_address", (32'd3 << 14) | offset, 32'(rom_address));
	end
endtask

task automatic sg_ram_access();
	cart_flags_t cart_flags;
	logic [31:0] offset;
	byte_t       data;
	cart_flags           = '0;
	cart_flags.supergame = 1'b1;
	cart_flags.sg_ram_4k = 1'b1;
	load_cart(cart_flags, 32'h20000);
	for (int i = 0; i < 4; i++) begin
		offset = next_random() & 32'h3fff;
		data   = byte_t'(next_random());
		present_bus(16'h4000 | addr_t'(offset), data, 1'b0);
		check_value("cartram_wr", 32'd1, 32'(cartram_wr));
		check_value("cartram_addr", offset, 32'(cartram_addr));
		check_value("cartram_wrdata", 32'(data), 32'(cartram_wrdata));
		present_bus(16'h4000 | addr_t'(offset), 8'h00, 1'b1);
		check_value("cartram_rd", 32'd1, 32'(cartram_rd));
		check_value("dout", 32'(ram_data), 32'(dout));
		check_value("cart_read", 32'd0, 32'(cart_read));
	end
	// mirrored ram drops address bits 8, 12 and 13
	cart_flags.sg_ram_4k  = 1'b0;
	cart_flags.mirror_ram = 1'b1;
	load_cart(cart_flags, 32'h20000);
	for (int i = 0; i < 4; i++) begin
		offset = next_random() & 32'h3fff;
		data   = byte_t'(next_random());
		present_bus(16'h4000 | addr_t'(offset), data, 1'b0);
		check_value("cartram_addr", offset & ~32'h3100, 32'(cartram_addr));
	end
endtask

task automatic covox_sums();
	byte_t       regs [4];
	logic [31:0] sum;
	apply_reset();
	check_value("covox_l", 32'd0, 32'(covox_l));
	check_value("covox_r", 32'd0, 32'(covox_r));
	for (int i = 0; i < 4; i++) begin
		regs[i] = byte_t'(next_random());
		bus_write(16'h0430 + 16'(i), regs[i]);
	end
	sum = (32'(regs[0]) + 32'(regs[2])) << 7;
	check_value("covox_r", sum, 32'(covox_r));
	sum = (32'(regs[1]) + 32'(regs[3])) << 7;
	check_value("covox_l", sum, 32'(covox_l));
endtask

`endif

// File: tb/tb_cart.sv
////////////////////////////////////////////////////////////
// cart mapper testbench with clock, reset, dut and tests
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_cart;
	import cart_pkg::*;

	localparam int clk_half        = 50;
	localparam int drive_skew      = 5;
	localparam int watchdog_cycles = 2000;

	logic        clk_sys;
	logic        reset;
	cpu_bus_t    bus;
	logic        pclk0;
	logic        pclk1;
	cart_flags_t flags;
	logic [31:0] cart_size;
	byte_t       rom_data;
	byte_t       ram_data;
	byte_t       open_bus;
	byte_t       dout;
	logic        cart_read;
	rom_addr_t   rom_address;
	ram_addr_t   cartram_addr;
	logic        cartram_wr;
	logic        cartram_rd;
	byte_t       cartram_wrdata;
	logic [15:0] covox_l;
	logic [15:0] covox_r;
	logic [31:0] rng_state;

	cart_top dut (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.bus            (bus),
		.pclk0          (pclk0),
		.pclk1          (pclk1),
		.flags          (flags),
		.cart_size      (cart_size),
		.rom_data       (rom_data),
		.ram_data       (ram_data),
		.open_bus       (open_bus),
		.dout           (dout),
		.cart_read      (cart_read),
		.rom_address    (rom_address),
		.cartram_addr   (cartram_addr),
		.cartram_wr     (cartram_wr),
		.cartram_rd     (cartram_rd),
		.cartram_wrdata (cartram_wrdata),
		.covox_l        (covox_l),
		.covox_r        (covox_r)
	);

	// 100 ns period
	always #clk_half clk_sys = ~clk_sys;

	// the six tests need a few hundred cycles at most
	initial begin
		repeat (watchdog_cycles) @(posedge clk_sys);
		$display("Test failures found");
		$fatal(1, "watchdog expired after %0d cycles, the tests did not finish",
			watchdog_cycles);
	end

	function automatic logic [31:0] xorshift(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("[FAIL] time %0t ns: %s expected 0x%0h, got 0x%0h",
				$time, name, expected, actual);
			$display("Test failures found");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	`include "cart_tests.svh"

	initial begin
		clk_sys   = 1'b0;
		reset     = 1'b1;
		pclk0     = 1'b0;
		pclk1     = 1'b0;
		flags     = '0;
		cart_size = 32'h0;
		rom_data  = 8'h00;
		ram_data  = 8'h00;
		open_bus  = 8'h00;
		rng_state = 32'hc16d;
		idle_bus();
		repeat (2) @(posedge clk_sys);
		#drive_skew;
		reset = 1'b0;

		unbanked_16k_reads();
		supergame_128k_banking();
		activision_banking();
		absolute_banking();
		sg_ram_access();
		covox_sums();

		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire
